/* key_extract_pkg.sv */
package key_extract_pkg;

    // container widths in bits
    localparam int W2B = 16;
    localparam int W4B = 32;
    localparam int W6B = 48;

    // containers per width and compare slots per PHV
    localparam int NUM_CONT = 8;
    localparam int NUM_CMP  = 5;

    // one table row per tenant
    localparam int TABLE_DEPTH = 16;
    localparam int TABLE_AW    = 4;

    localparam int          CTRL_DATA_W   = 256;
    localparam logic [15:0] CTRL_MAGIC    = 16'hf2f1;
    localparam logic [3:0]  TABLE_SEL_OFF = 4'd0;

    // compare functions, code 3 always yields 1
    localparam logic [1:0] CMP_GT = 2'd0;
    localparam logic [1:0] CMP_GE = 2'd1;
    localparam logic [1:0] CMP_EQ = 2'd2;

    // container type of a compare operand
    localparam logic [1:0] CONT_2B = 2'd0;
    localparam logic [1:0] CONT_4B = 2'd1;
    localparam logic [1:0] CONT_6B = 2'd2;

    // container 7 sits in the top bits
    typedef logic [NUM_CONT-1:0][W6B-1:0] cont_6b_t;
    typedef logic [NUM_CONT-1:0][W4B-1:0] cont_4b_t;
    typedef logic [NUM_CONT-1:0][W2B-1:0] cont_2b_t;

    typedef struct packed {
        logic       imm;
        // immediate value, or type in [4:3] and container index in [2:0]
        logic [7:0] value;
    } cmp_opnd_t;

    typedef struct packed {
        logic [1:0] func;
        cmp_opnd_t  opnd_a;
        cmp_opnd_t  opnd_b;
    } cmp_op_t;

    typedef struct packed {
        logic [114:0] rsvd_hi;
        logic [11:0]  vlan_id;
        logic [128:0] rsvd_lo;
    } phv_meta_t;

    // slot 0 of cmp_op is the highest
    typedef struct packed {
        cont_6b_t              cont_6b;
        cont_4b_t              cont_4b;
        cont_2b_t              cont_2b;
        cmp_op_t [0:NUM_CMP-1] cmp_op;
        phv_meta_t             meta;
    } phv_t;

    typedef struct packed {
        logic [W6B-1:0]     f6b_0;
        logic [W6B-1:0]     f6b_1;
        logic [W4B-1:0]     f4b_0;
        logic [W4B-1:0]     f4b_1;
        logic [W2B-1:0]     f2b_0;
        logic [W2B-1:0]     f2b_1;
        logic [NUM_CMP-1:0] cmp_vec;
    } key_t;

    // container index per key field, same order as key_t
    typedef struct packed {
        logic [2:0] sel_6b_0;
        logic [2:0] sel_6b_1;
        logic [2:0] sel_4b_0;
        logic [2:0] sel_4b_1;
        logic [2:0] sel_2b_0;
        logic [2:0] sel_2b_1;
    } key_off_t;

    typedef struct packed {
        logic [119:0] rsvd_hi;
        logic [7:0]   start_index;
        logic [3:0]   rsvd_sel;
        logic [3:0]   table_sel;
        logic [4:0]   stage_id;
        logic [2:0]   block_id;
        logic [31:0]  rsvd_mid;
        logic [15:0]  flag;
        logic [63:0]  rsvd_lo;
    } ctrl_hdr_t;

    typedef struct packed {
        logic [CTRL_DATA_W-1:0] data;
        logic                   last;
    } ctrl_beat_t;

endpackage

/* key_table.sv */
`timescale 1ns/100ps

module key_table
    import key_extract_pkg::*;
#(
    parameter type entry_t = logic [7:0]
) (
    input  logic                clk,
    input  logic                wr_en,
    input  logic [TABLE_AW-1:0] wr_addr,
    input  entry_t              wr_data,
    input  logic [TABLE_AW-1:0] rd_addr,
    output entry_t              rd_data
);

    // one row per tenant, maps onto block RAM
    entry_t mem [TABLE_DEPTH];

    always_ff @(posedge clk) begin
        if (wr_en) begin
            mem[wr_addr] <= wr_data;
        end
        // read returns the old row on a same-address write
        rd_data <= mem[rd_addr];
    end

endmodule

/* table_config_fsm.sv */
`timescale 1ns/100ps

module table_config_fsm
    import key_extract_pkg::*;
#(
    parameter int STAGE_ID = 0,
    parameter int BLOCK_ID = 1
) (
    input  logic                   clk,
    input  logic                   rst_n,
    input  ctrl_beat_t             ctrl_in,
    input  logic                   ctrl_valid,
    output logic [TABLE_AW-1:0]    wr_addr,
    output logic                   off_wr_en,
    output logic                   mask_wr_en,
    output logic [CTRL_DATA_W-1:0] wr_data
);

    typedef enum logic [1:0] {
        ST_IDLE,
        ST_WRITE,
        ST_SKIP
    } state_t;

    state_t              state;
    ctrl_hdr_t           hdr;
    logic                hdr_match;
    logic                entry_beat;
    logic                sel_off;
    logic [TABLE_AW-1:0] next_idx;

    assign hdr = ctrl_hdr_t'(ctrl_in.data);

    // packet is ours only with the right module id and the magic flag
    assign hdr_match = (hdr.stage_id == 5'(STAGE_ID))
                    && (hdr.block_id == 3'(BLOCK_ID))
                    && (hdr.flag == CTRL_MAGIC);

    assign entry_beat = ctrl_valid && (state == ST_WRITE);

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            state      <= ST_IDLE;
            sel_off    <= 1'b0;
            next_idx   <= '0;
            off_wr_en  <= 1'b0;
            mask_wr_en <= 1'b0;
        end else begin
            // one write per entry beat, never both tables
            off_wr_en  <= entry_beat && sel_off;
            mask_wr_en <= entry_beat && !sel_off;

            case (state)
                ST_IDLE: begin
                    // a header with last set carries no entries
                    if (ctrl_valid && !ctrl_in.last) begin
                        if (hdr_match) begin
                            sel_off  <= (hdr.table_sel == TABLE_SEL_OFF);
                            // index wraps within the 16-row table
                            next_idx <= hdr.start_index[TABLE_AW-1:0];
                            state    <= ST_WRITE;
                        end else begin
                            state <= ST_SKIP;
                        end
                    end
                end
                ST_WRITE: begin
                    if (ctrl_valid) begin
                        next_idx <= next_idx + 1'b1;
                        if (ctrl_in.last) begin
                            state <= ST_IDLE;
                        end
                    end
                end
                ST_SKIP: begin
                    // drop foreign packets up to their last beat
                    if (ctrl_valid && ctrl_in.last) begin
                        state <= ST_IDLE;
                    end
                end
                default: begin
                    state <= ST_IDLE;
                end
            endcase
        end
    end

    // entry and address registered alongside the enables
    always_ff @(posedge clk) begin
        if (entry_beat) begin
            wr_addr <= next_idx;
            wr_data <= ctrl_in.data;
        end
    end

endmodule

/* key_compare.sv */
`timescale 1ns/100ps

module key_compare
    import key_extract_pkg::*;
(
    input  cont_6b_t cont_6b,
    input  cont_4b_t cont_4b,
    input  cont_2b_t cont_2b,
    input  cmp_op_t  op,
    output logic     result
);

    logic [7:0] opnd_a;
    logic [7:0] opnd_b;

    // immediate, or low byte of the addressed container
    function automatic logic [7:0] pick_operand(
        input cmp_opnd_t opnd,
        input cont_6b_t  c6,
        input cont_4b_t  c4,
        input cont_2b_t  c2
    );
        logic [1:0] kind;
        logic [2:0] idx;
        kind = opnd.value[4:3];
        idx  = opnd.value[2:0];
        if (opnd.imm) begin
            return opnd.value;
        end
        case (kind)
            CONT_6B: return c6[idx][7:0];
            CONT_4B: return c4[idx][7:0];
            CONT_2B: return c2[idx][7:0];
            default: return 8'd0;
        endcase
    endfunction

    assign opnd_a = pick_operand(op.opnd_a, cont_6b, cont_4b, cont_2b);
    assign opnd_b = pick_operand(op.opnd_b, cont_6b, cont_4b, cont_2b);

    // unsigned byte compare
    always_comb begin
        case (op.func)
            CMP_GT:  result = (opnd_a > opnd_b);
            CMP_GE:  result = (opnd_a >= opnd_b);
            CMP_EQ:  result = (opnd_a == opnd_b);
            default: result = 1'b1;
        endcase
    end

endmodule

/* key_assembler.sv */
`timescale 1ns/100ps

module key_assembler
    import key_extract_pkg::*;
#(
    parameter int STAGE_ID = 0
) (
    input  logic                clk,
    input  logic                rst_n,
    input  phv_t                phv_in,
    input  logic                phv_valid,
    input  key_off_t            key_off,
    input  key_t                key_mask,
    output logic [TABLE_AW-1:0] tenant,
    output phv_t                phv_out,
    output logic                phv_valid_out,
    output key_t                key_out,
    output logic                key_valid_out,
    output key_t                key_mask_out
);

    // this stage owns one bit of the compare vector
    localparam int CMP_POS = NUM_CMP - 1 - STAGE_ID;

    phv_t     phv_s1;
    phv_t     phv_s2;
    logic     valid_s1;
    logic     valid_s2;
    key_off_t off_s2;
    key_t     mask_s2;
    logic     cmp_bit;
    key_t     key_next;

    // table read runs in parallel with stage 1
    assign tenant = phv_in.meta.vlan_id[7:4];

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            valid_s1      <= 1'b0;
            valid_s2      <= 1'b0;
            phv_valid_out <= 1'b0;
            key_valid_out <= 1'b0;
            key_out       <= '0;
        end else begin
            valid_s1      <= phv_valid;
            valid_s2      <= valid_s1;
            phv_valid_out <= valid_s2;
            key_valid_out <= valid_s2;
            // idle cycles present an all-zero key
            key_out       <= valid_s2 ? key_next : '0;
        end
    end

    // stage 1 holds the PHV while the tables are read
    // stage 2 holds containers and compare ops with the table rows
    always_ff @(posedge clk) begin
        phv_s1       <= phv_in;
        phv_s2       <= phv_s1;
        off_s2       <= key_off;
        mask_s2      <= key_mask;
        phv_out      <= phv_s2;
        key_mask_out <= mask_s2;
    end

    key_compare u_key_compare (
        .cont_6b (phv_s2.cont_6b),
        .cont_4b (phv_s2.cont_4b),
        .cont_2b (phv_s2.cont_2b),
        .op      (phv_s2.cmp_op[STAGE_ID]),
        .result  (cmp_bit)
    );

    // container select by the tenant's offset row
    always_comb begin
        key_next                  = '0;
        key_next.f6b_0            = phv_s2.cont_6b[off_s2.sel_6b_0];
        key_next.f6b_1            = phv_s2.cont_6b[off_s2.sel_6b_1];
        key_next.f4b_0            = phv_s2.cont_4b[off_s2.sel_4b_0];
        key_next.f4b_1            = phv_s2.cont_4b[off_s2.sel_4b_1];
        key_next.f2b_0            = phv_s2.cont_2b[off_s2.sel_2b_0];
        key_next.f2b_1            = phv_s2.cont_2b[off_s2.sel_2b_1];
        // other compare bits belong to other stages
        key_next.cmp_vec[CMP_POS] = cmp_bit;
    end

endmodule

/* key_extract_top.sv */
`timescale 1ns/100ps

module key_extract_top
    import key_extract_pkg::*;
#(
    parameter int STAGE_ID = 0,
    parameter int BLOCK_ID = 1
) (
    input  logic       clk,
    input  logic       rst_n,
    input  phv_t       phv_in,
    input  logic       phv_valid,
    input  ctrl_beat_t ctrl_in,
    input  logic       ctrl_valid,
    output phv_t       phv_out,
    output logic       phv_valid_out,
    output key_t       key_out,
    output logic       key_valid_out,
    output key_t       key_mask_out
);

    logic [TABLE_AW-1:0]    tenant;
    logic [TABLE_AW-1:0]    cfg_wr_addr;
    logic                   off_wr_en;
    logic                   mask_wr_en;
    logic [CTRL_DATA_W-1:0] cfg_wr_data;
    key_off_t               key_off;
    key_t                   key_mask;

    table_config_fsm #(
        .STAGE_ID (STAGE_ID),
        .BLOCK_ID (BLOCK_ID)
    ) u_table_config_fsm (
        .clk        (clk),
        .rst_n      (rst_n),
        .ctrl_in    (ctrl_in),
        .ctrl_valid (ctrl_valid),
        .wr_addr    (cfg_wr_addr),
        .off_wr_en  (off_wr_en),
        .mask_wr_en (mask_wr_en),
        .wr_data    (cfg_wr_data)
    );

    // entries sit in the low bits of the beat
    key_table #(
        .entry_t (key_off_t)
    ) offset_table (
        .clk     (clk),
        .wr_en   (off_wr_en),
        .wr_addr (cfg_wr_addr),
        .wr_data (cfg_wr_data[$bits(key_off_t)-1:0]),
        .rd_addr (tenant),
        .rd_data (key_off)
    );

    key_table #(
        .entry_t (key_t)
    ) mask_table (
        .clk     (clk),
        .wr_en   (mask_wr_en),
        .wr_addr (cfg_wr_addr),
        .wr_data (cfg_wr_data[$bits(key_t)-1:0]),
        .rd_addr (tenant),
        .rd_data (key_mask)
    );

    key_assembler #(
        .STAGE_ID (STAGE_ID)
    ) u_key_assembler (
        .clk           (clk),
        .rst_n         (rst_n),
        .phv_in        (phv_in),
        .phv_valid     (phv_valid),
        .key_off       (key_off),
        .key_mask      (key_mask),
        .tenant        (tenant),
        .phv_out       (phv_out),
        .phv_valid_out (phv_valid_out),
        .key_out       (key_out),
        .key_valid_out (key_valid_out),
        .key_mask_out  (key_mask_out)
    );

endmodule

/* key_extract_properties.sv */
`timescale 1ns/100ps

module key_extract_properties
    import key_extract_pkg::*;
(
    input logic clk,
    input logic rst_n,
    input logic phv_valid,
    input logic phv_valid_out,
    input logic key_valid_out,
    input key_t key_out,
    input logic off_wr_en,
    input logic mask_wr_en
);

    a_valid_pair: assert property (@(posedge clk) disable iff (!rst_n)
        key_valid_out == phv_valid_out)
        else $error("key_valid_out differs from phv_valid_out");

    // three register stages from input to output
    a_latency: assert property (@(posedge clk) disable iff (!rst_n)
        phv_valid_out == $past(phv_valid, 3))
        else $error("phv_valid_out does not follow phv_valid by three cycles");

    a_one_table: assert property (@(posedge clk) disable iff (!rst_n)
        !(off_wr_en && mask_wr_en))
        else $error("both table write enables high");

    a_idle_key: assert property (@(posedge clk)
        !key_valid_out |-> key_out == '0)
        else $error("key_out nonzero while not valid");

endmodule

bind key_extract_top key_extract_properties u_key_extract_properties (
    .clk           (clk),
    .rst_n         (rst_n),
    .phv_valid     (phv_valid),
    .phv_valid_out (phv_valid_out),
    .key_valid_out (key_valid_out),
    .key_out       (key_out),
    .off_wr_en     (off_wr_en),
    .mask_wr_en    (mask_wr_en)
);

/* tb_key_extract.sv */
`timescale 1ns/100ps

module tb_key_extract;
    import key_extract_pkg::*;

    localparam int          STAGE_ID   = 0;
    localparam int          BLOCK_ID   = 1;
    localparam int          CLK_PERIOD = 8;
    localparam int          NUM_ROWS   = 12;
    localparam int          WDOG_CYC   = NUM_ROWS * 10 + 200;
    localparam logic [31:0] SEED       = 32'h41b06131;

    // per-tenant table contents, tenants 5 and 6
    localparam key_off_t OFF_T5  = {3'd7, 3'd0, 3'd2, 3'd5, 3'd1, 3'd6};
    localparam key_off_t OFF_T6  = {3'd1, 3'd4, 3'd6, 3'd0, 3'd3, 3'd2};
    localparam key_t     MASK_T5 = {48'hffff_ffff_ffff, 48'h0000_ffff_0000, 32'hffff_ffff,
                                    32'h00ff_00ff, 16'hffff, 16'h0f0f, 5'b10000};
    localparam key_t     MASK_T6 = {48'h0000_0000_ffff, 48'hffff_ffff_ffff, 32'hf0f0_f0f0,
                                    32'hffff_ffff, 16'h00ff, 16'hffff, 5'b10000};

    typedef struct {
        logic [3:0]  tenant;
        key_off_t    off;
        key_t        mask;
        cmp_op_t     op;
        logic [31:0] cont_seed;
    } row_t;

    typedef struct {
        phv_t        phv;
        key_t        key;
        key_t        mask;
        int unsigned cyc;
    } exp_t;

    logic       clk = 1'b0;
    logic       rst_n;
    phv_t       phv_in;
    logic       phv_valid;
    ctrl_beat_t ctrl_in;
    logic       ctrl_valid;
    phv_t       phv_out;
    logic       phv_valid_out;
    key_t       key_out;
    logic       key_valid_out;
    key_t       key_mask_out;

    row_t        rows [NUM_ROWS];
    exp_t        exp_q [$];
    int unsigned cycle = 0;
    int unsigned checked = 0;

    key_extract_top #(
        .STAGE_ID (STAGE_ID),
        .BLOCK_ID (BLOCK_ID)
    ) u_key_extract_top (
        .clk           (clk),
        .rst_n         (rst_n),
        .phv_in        (phv_in),
        .phv_valid     (phv_valid),
        .ctrl_in       (ctrl_in),
        .ctrl_valid    (ctrl_valid),
        .phv_out       (phv_out),
        .phv_valid_out (phv_valid_out),
        .key_out       (key_out),
        .key_valid_out (key_valid_out),
        .key_mask_out  (key_mask_out)
    );

    always #(CLK_PERIOD / 2) clk = ~clk;

    always @(posedge clk) begin
        cycle <= cycle + 1;
    end

    task automatic stop_on_error(input string msg);
        $display("%s", msg);
        $display("*** FAILED ***");
        $fatal(1, "simulation stopped at first error");
    endtask

    function automatic logic [31:0] xorshift32(input logic [31:0] s);
        s = s ^ (s << 13);
        s = s ^ (s >> 17);
        s = s ^ (s << 5);
        return s;
    endfunction

    function automatic cmp_opnd_t imm_opnd(input logic [7:0] v);
        cmp_opnd_t o;
        o.imm   = 1'b1;
        o.value = v;
        return o;
    endfunction

    // container operand: type 2 = 6B, 1 = 4B, 0 = 2B
    function automatic cmp_opnd_t cont_opnd(input logic [1:0] kind, input logic [2:0] idx);
        cmp_opnd_t o;
        o.imm   = 1'b0;
        o.value = {3'b000, kind, idx};
        return o;
    endfunction

    function automatic cmp_op_t make_op(input logic [1:0] f, input cmp_opnd_t a,
                                        input cmp_opnd_t b);
        cmp_op_t op;
        op.func   = f;
        op.opnd_a = a;
        op.opnd_b = b;
        return op;
    endfunction

    task automatic set_row(input int i, input logic [3:0] tenant, input cmp_op_t op);
        rows[i].tenant    = tenant;
        rows[i].off       = (tenant == 4'd5) ? OFF_T5 : OFF_T6;
        rows[i].mask      = (tenant == 4'd5) ? MASK_T5 : MASK_T6;
        rows[i].op        = op;
        rows[i].cont_seed = 32'h100 + i;
    endtask

    function automatic phv_t build_phv(input row_t r);
        phv_t        p;
        logic [31:0] s;
        p = '0;
        s = SEED ^ r.cont_seed;
        for (int i = 0; i < NUM_CONT; i++) begin
            s = xorshift32(s);
            p.cont_6b[i][47:32] = s[15:0];
            s = xorshift32(s);
            p.cont_6b[i][31:0] = s;
            s = xorshift32(s);
            p.cont_4b[i] = s;
            s = xorshift32(s);
            p.cont_2b[i] = s[15:0];
        end
        // foreign compare slots get noise
        for (int i = 0; i < NUM_CMP; i++) begin
            s = xorshift32(s);
            p.cmp_op[i] = (i == STAGE_ID) ? r.op : cmp_op_t'(s[19:0]);
        end
        s = xorshift32(s);
        p.meta.rsvd_lo[31:0] = s;
        p.meta.vlan_id = {s[11:8], r.tenant, s[3:0]};
        return p;
    endfunction

    function automatic logic [7:0] operand_byte(input cmp_opnd_t o, input phv_t p);
        if (o.imm) begin
            return o.value;
        end
        case (o.value[4:3])
            2'd2:    return p.cont_6b[o.value[2:0]][7:0];
            2'd1:    return p.cont_4b[o.value[2:0]][7:0];
            2'd0:    return p.cont_2b[o.value[2:0]][7:0];
            default: return 8'd0;
        endcase
    endfunction

    function automatic key_t expected_key(input phv_t p, input key_off_t off);
        key_t       k;
        cmp_op_t    op;
        logic [7:0] a;
        logic [7:0] b;
        logic       hit;
        k       = '0;
        k.f6b_0 = p.cont_6b[off.sel_6b_0];
        k.f6b_1 = p.cont_6b[off.sel_6b_1];
        k.f4b_0 = p.cont_4b[off.sel_4b_0];
        k.f4b_1 = p.cont_4b[off.sel_4b_1];
        k.f2b_0 = p.cont_2b[off.sel_2b_0];
        k.f2b_1 = p.cont_2b[off.sel_2b_1];
        op = p.cmp_op[STAGE_ID];
        a  = operand_byte(op.opnd_a, p);
        b  = operand_byte(op.opnd_b, p);
        case (op.func)
            2'd0:    hit = (a > b);
            2'd1:    hit = (a >= b);
            2'd2:    hit = (a == b);
            default: hit = 1'b1;
        endcase
        k.cmp_vec[NUM_CMP - 1 - STAGE_ID] = hit;
        return k;
    endfunction

    // header, two entries, then idle gap
    task automatic send_ctrl_packet(input logic [4:0] stage, input logic [15:0] flag,
                                    input logic [3:0] sel, input logic [7:0] start,
                                    input logic [CTRL_DATA_W-1:0] entry_0,
                                    input logic [CTRL_DATA_W-1:0] entry_1);
        ctrl_hdr_t hdr;
        hdr             = '0;
        hdr.stage_id    = stage;
        hdr.block_id    = 3'(BLOCK_ID);
        hdr.flag        = flag;
        hdr.table_sel   = sel;
        hdr.start_index = start;
        ctrl_in.data = hdr;
        ctrl_in.last = 1'b0;
        ctrl_valid   = 1'b1;
        @(negedge clk);
        ctrl_in.data = entry_0;
        @(negedge clk);
        ctrl_in.data = entry_1;
        ctrl_in.last = 1'b1;
        @(negedge clk);
        ctrl_valid = 1'b0;
        ctrl_in    = '0;
        repeat (3) @(negedge clk);
    endtask

    // output monitor, outputs settle after the rising edge
    always @(negedge clk) begin
        exp_t e;
        if (key_valid_out === 1'b1) begin
            assert (exp_q.size() > 0) else
                stop_on_error($sformatf("Error at %0t ns: unexpected valid key", $time));
            e = exp_q.pop_front();
            assert (e.cyc == cycle) else
                stop_on_error($sformatf("Error at %0t ns: output in cycle %0d, expected %0d",
                                        $time, cycle, e.cyc));
            assert (phv_valid_out === 1'b1) else
                stop_on_error($sformatf("Error at %0t ns: phv_valid_out low with key", $time));
            assert (key_out === e.key) else
                stop_on_error($sformatf("Error at %0t ns: key_out %h, expected %h",
                                        $time, key_out, e.key));
            assert (key_mask_out === e.mask) else
                stop_on_error($sformatf("Error at %0t ns: key_mask_out %h, expected %h",
                                        $time, key_mask_out, e.mask));
            assert (phv_out === e.phv) else
                stop_on_error($sformatf("Error at %0t ns: phv_out differs from input PHV",
                                        $time));
            checked++;
        end else begin
            assert (key_valid_out === 1'b0 && phv_valid_out === 1'b0) else
                stop_on_error($sformatf("Error at %0t ns: valid outputs %b/%b while idle",
                                        $time, key_valid_out, phv_valid_out));
            assert (key_out === '0) else
                stop_on_error($sformatf("Error at %0t ns: key_out %h while idle",
                                        $time, key_out));
            if (exp_q.size() > 0) begin
                assert (exp_q[0].cyc > cycle) else
                    stop_on_error($sformatf("Error at %0t ns: key for cycle %0d missing",
                                            $time, exp_q[0].cyc));
            end
        end
    end

    initial begin
        #(WDOG_CYC * CLK_PERIOD);
        stop_on_error("Timeout: the DUT did not deliver all keys within the watchdog limit");
    end

    initial begin
        phv_t p;
        exp_t e;
        rst_n      = 1'b0;
        phv_in     = '0;
        phv_valid  = 1'b0;
        ctrl_in    = '0;
        ctrl_valid = 1'b0;

        // immediates pin the outcome, container rows follow the model
        set_row(0, 4'd5, make_op(CMP_GT, imm_opnd(8'h20), imm_opnd(8'h10)));
        set_row(1, 4'd6, make_op(CMP_GT, imm_opnd(8'h10), imm_opnd(8'h20)));
        set_row(2, 4'd5, make_op(CMP_GE, imm_opnd(8'h44), imm_opnd(8'h44)));
        set_row(3, 4'd6, make_op(CMP_GE, imm_opnd(8'h43), imm_opnd(8'h44)));
        set_row(4, 4'd5, make_op(CMP_EQ, imm_opnd(8'h5a), imm_opnd(8'h5a)));
        set_row(5, 4'd6, make_op(CMP_EQ, imm_opnd(8'h5a), imm_opnd(8'h5b)));
        set_row(6, 4'd5, make_op(2'd3, imm_opnd(8'h00), imm_opnd(8'hff)));
        set_row(7, 4'd6, make_op(CMP_GT, cont_opnd(2'd2, 3'd3), imm_opnd(8'h80)));
        set_row(8, 4'd5, make_op(CMP_EQ, cont_opnd(2'd1, 3'd2), cont_opnd(2'd1, 3'd2)));
        set_row(9, 4'd6, make_op(CMP_GE, cont_opnd(2'd0, 3'd6), cont_opnd(2'd2, 3'd1)));
        set_row(10, 4'd5, make_op(CMP_GT, cont_opnd(2'd0, 3'd4), cont_opnd(2'd0, 3'd4)));
        set_row(11, 4'd6, make_op(2'd3, cont_opnd(2'd1, 3'd7), cont_opnd(2'd2, 3'd0)));

        repeat (4) @(posedge clk);
        @(negedge clk);
        rst_n = 1'b1;
        repeat (2) @(negedge clk);

        // rows 0 and 1 hold tenants 5 and 6
        send_ctrl_packet(5'(STAGE_ID), CTRL_MAGIC, 4'd0, 8'd5,
                         CTRL_DATA_W'(rows[0].off), CTRL_DATA_W'(rows[1].off));
        send_ctrl_packet(5'(STAGE_ID), CTRL_MAGIC, 4'd1, 8'd5,
                         CTRL_DATA_W'(rows[0].mask), CTRL_DATA_W'(rows[1].mask));
        // foreign stage and bad flag must leave the tables alone
        send_ctrl_packet(5'(STAGE_ID + 2), CTRL_MAGIC, 4'd0, 8'd5,
                         {CTRL_DATA_W{1'b1}}, {CTRL_DATA_W{1'b1}});
        send_ctrl_packet(5'(STAGE_ID), 16'hf2f0, 4'd1, 8'd5,
                         {CTRL_DATA_W{1'b1}}, {CTRL_DATA_W{1'b1}});
        repeat (4) @(negedge clk);

        // back-to-back PHVs, one per cycle
        for (int i = 0; i < NUM_ROWS; i++) begin
            p      = build_phv(rows[i]);
            e.phv  = p;
            e.key  = expected_key(p, rows[i].off);
            e.mask = rows[i].mask;
            e.cyc  = cycle + 3;
            exp_q.push_back(e);
            phv_in    = p;
            phv_valid = 1'b1;
            @(negedge clk);
        end
        phv_valid = 1'b0;
        phv_in    = '0;

        while (checked < NUM_ROWS) begin
            @(negedge clk);
        end
        repeat (8) @(negedge clk);

        if (checked == NUM_ROWS && exp_q.size() == 0) begin
            $display("*** PASSED ***");
            $finish;
        end else begin
            stop_on_error($sformatf("Error at %0t ns: %0d of %0d keys checked",
                                    $time, checked, NUM_ROWS));
        end
    end

endmodule

/* project.f */
key_extract_pkg.sv
key_table.sv
table_config_fsm.sv
key_compare.sv
key_assembler.sv
key_extract_top.sv
key_extract_properties.sv
tb_key_extract.sv
